/* logic/mbox_pkg.sv */
// ******************************
// Mailbox shared types, register map offsets,
// reset value and bus/queue structs
// ******************************

package mbox_pkg;

	// ******************************
	// Widths
	// ******************************
	typedef logic [31:0] word_t;
	typedef logic [4:0] paddr_t;
	typedef logic [2:0] reg_idx_t;
	typedef logic [7:0] cnt_t;
	typedef logic [2:0] status_t;

	// Register indices
	localparam reg_idx_t IDX_STATUS = 3'd0;
	localparam reg_idx_t IDX_CMD = 3'd1;
	localparam reg_idx_t IDX_CONFIG = 3'd2;
	localparam reg_idx_t IDX_QUEUE0 = 3'd3;

	// Byte offsets on the bus
	localparam paddr_t OFS_STATUS = 5'h00;
	localparam paddr_t OFS_CMD = 5'h04;
	localparam paddr_t OFS_CONFIG = 5'h08;
	localparam paddr_t OFS_QUEUE0 = 5'h0C;
	localparam int OFS_QUEUE_STEP = 4;

	localparam word_t CONFIG_RESET = 32'h0000_0100;
	localparam int NUM_QUEUES = 4;

	// ******************************
	// Structs
	// ******************************
	typedef struct packed {
		logic sel;
		logic enable;
		logic write;
		paddr_t addr;
		word_t wdata;
	} apb_req_t;

	typedef struct packed {
		reg_idx_t idx;
		logic wr;
		logic rd;
	} reg_cmd_t;

	typedef struct packed {
		word_t data;
		logic empty;
		cnt_t count;
	} queue_out_t;

endpackage

/* logic/apb_decode.sv */
// ******************************
// Bus access decode into register index and
// read/write strobes, with slave error flag
// ******************************

`timescale 1ns/1ns

module apb_decode
(
	input mbox_pkg::apb_req_t req,
	output mbox_pkg::reg_cmd_t cmd,
	output logic slverr
);

	import mbox_pkg::*;

	logic access;
	logic misaligned;
	logic hit;
	reg_idx_t idx;

	// Access phase only
	assign access = req.sel & req.enable;
	assign misaligned = |req.addr[1:0];

	always_comb
	begin
		hit = 1'b0;
		idx = IDX_STATUS;
		case (req.addr)
			OFS_STATUS:
			begin
				hit = 1'b1;
				idx = IDX_STATUS;
			end
			OFS_CMD:
			begin
				hit = 1'b1;
				idx = IDX_CMD;
			end
			OFS_CONFIG:
			begin
				hit = 1'b1;
				idx = IDX_CONFIG;
			end
			default:
			begin
				// Queue window
				for (int q = 0; q < NUM_QUEUES; q++)
				begin
					if (req.addr == paddr_t'(OFS_QUEUE0 + OFS_QUEUE_STEP * q))
					begin
						hit = 1'b1;
						idx = reg_idx_t'(IDX_QUEUE0 + q);
					end
				end
			end
		endcase
	end

	assign slverr = access & (misaligned | ~hit);

	assign cmd.idx = idx;
	assign cmd.wr = access & hit & ~misaligned & req.write;
	assign cmd.rd = access & hit & ~misaligned & ~req.write;

endmodule

/* logic/mbox_fifo.sv */
// ******************************
// First-word-fall-through queue with fill count
// ******************************

`timescale 1ns/1ns

module mbox_fifo
#(
	parameter int FIFO_DEPTH = 8
)
(
	input logic rvx_port_21,
	input logic rvx_port_17,
	input logic push,
	input mbox_pkg::word_t wdata,
	input logic pop,
	output mbox_pkg::queue_out_t q,
	output logic full
);

	import mbox_pkg::*;

	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	typedef logic [AW-1:0] ptr_t;

	word_t mem [FIFO_DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	cnt_t count;
	logic empty;
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full = (count == cnt_t'(FIFO_DEPTH));

	// Push to full and pop from empty are dropped
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	always_ff @(posedge rvx_port_21 or negedge rvx_port_17)
	begin
		if (!rvx_port_17)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage
	always_ff @(posedge rvx_port_21)
	begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	// Head word is always visible
	assign q.data = mem[rd_ptr];
	assign q.empty = empty;
	assign q.count = count;

endmodule

/* logic/mbox_regs.sv */
// ******************************
// Execute stage: config register, command
// pulse and the four write queues
// ******************************

`timescale 1ns/1ns

module mbox_regs
#(
	parameter int FIFO_DEPTH = 8
)
(
	input logic rvx_port_21,
	input logic rvx_port_17,
	input mbox_pkg::reg_cmd_t cmd,
	input mbox_pkg::word_t wdata,
	input logic [mbox_pkg::NUM_QUEUES-1:0] pop,
	output mbox_pkg::word_t config_data,
	output logic cmd_pulse,
	output mbox_pkg::queue_out_t [mbox_pkg::NUM_QUEUES-1:0] queues
);

	import mbox_pkg::*;

	logic [NUM_QUEUES-1:0] push;
	logic [NUM_QUEUES-1:0] full;

	// ******************************
	// Config and command
	// ******************************
	always_ff @(posedge rvx_port_21 or negedge rvx_port_17)
	begin
		if (!rvx_port_17)
			config_data <= CONFIG_RESET;
		else if (cmd.wr && cmd.idx == IDX_CONFIG)
			config_data <= wdata;
	end

	// High for the one cycle after a CMD write
	always_ff @(posedge rvx_port_21 or negedge rvx_port_17)
	begin
		if (!rvx_port_17)
			cmd_pulse <= 1'b0;
		else
			cmd_pulse <= cmd.wr && cmd.idx == IDX_CMD;
	end

	// ******************************
	// Queues
	// ******************************
	for (genvar q = 0; q < NUM_QUEUES; q++)
	begin : g_queue
		assign push[q] = cmd.wr && cmd.idx == reg_idx_t'(IDX_QUEUE0 + q) && !full[q];

		mbox_fifo
		#(
			.FIFO_DEPTH(FIFO_DEPTH)
		)
		u_mbox_fifo
		(
			.rvx_port_21(rvx_port_21),
			.rvx_port_17(rvx_port_17),
			.push(push[q]),
			.wdata(wdata),
			.pop(pop[q]),
			.q(queues[q]),
			.full(full[q])
		);
	end

endmodule

/* logic/read_mux.sv */
// ******************************
// Result stage: read data by register index
// ******************************

`timescale 1ns/1ns

module read_mux
(
	input mbox_pkg::reg_cmd_t cmd,
	input mbox_pkg::status_t status,
	input mbox_pkg::word_t config_data,
	input mbox_pkg::queue_out_t [mbox_pkg::NUM_QUEUES-1:0] queues,
	output mbox_pkg::word_t rdata
);

	import mbox_pkg::*;

	word_t sel_word;

	always_comb
	begin
		sel_word = '0;
		case (cmd.idx)
			IDX_STATUS: sel_word = word_t'(status);
			IDX_CMD: sel_word = '0;
			IDX_CONFIG: sel_word = config_data;
			default:
			begin
				// Queue reads return the fill count
				for (int q = 0; q < NUM_QUEUES; q++)
				begin
					if (cmd.idx == reg_idx_t'(IDX_QUEUE0 + q))
						sel_word = word_t'(queues[q].count);
				end
			end
		endcase
	end

	// Zero outside a read access
	assign rdata = cmd.rd ? sel_word : '0;

endmodule

/* logic/mbox_apb_top.sv */
// ******************************
// Mailbox peripheral on an APB-style bus
// ******************************

`timescale 1ns/1ns

module mbox_apb_top
#(
	parameter int FIFO_DEPTH = 8
)
(
	input logic rvx_port_21,
	input logic rvx_port_17,
	input mbox_pkg::apb_req_t req,
	input mbox_pkg::status_t status,
	input logic [mbox_pkg::NUM_QUEUES-1:0] pop,
	output mbox_pkg::word_t rdata,
	output logic slverr,
	output mbox_pkg::word_t config_data,
	output logic cmd_pulse,
	output mbox_pkg::queue_out_t [mbox_pkg::NUM_QUEUES-1:0] queues
);

	import mbox_pkg::*;

	reg_cmd_t cmd;

	apb_decode u_apb_decode
	(
		.req(req),
		.cmd(cmd),
		.slverr(slverr)
	);

	mbox_regs
	#(
		.FIFO_DEPTH(FIFO_DEPTH)
	)
	u_mbox_regs
	(
		.rvx_port_21(rvx_port_21),
		.rvx_port_17(rvx_port_17),
		.cmd(cmd),
		.wdata(req.wdata),
		.pop(pop),
		.config_data(config_data),
		.cmd_pulse(cmd_pulse),
		.queues(queues)
	);

	read_mux u_read_mux
	(
		.cmd(cmd),
		.status(status),
		.config_data(config_data),
		.queues(queues),
		.rdata(rdata)
	);

endmodule

/* tb/tb_mbox_apb_top.sv */
// ******************************
// Testbench for the mailbox peripheral
// ******************************

`timescale 1ns/1ns

module tb_mbox_apb_top;

	import mbox_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int DEPTH = 8;
	// Six tests of at most 300 cycles each, plus reset and margin
	localparam int TEST_CYCLES = 300;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 6 * TEST_CYCLES + 200;

	logic rvx_port_21;
	logic rvx_port_17;
	apb_req_t req;
	status_t status;
	logic [NUM_QUEUES-1:0] pop;
	word_t rdata;
	logic slverr;
	word_t config_data;
	logic cmd_pulse;
	queue_out_t [NUM_QUEUES-1:0] queues;

	// Reference contents of each queue, oldest word first
	word_t model [NUM_QUEUES][$];
	integer seed;
	int test_errs;
	int total_errs;
	int tests_run;
	int tests_bad;
	word_t rd_word;
	word_t wr_word;
	word_t cfg_expect;

	mbox_apb_top
	#(
		.FIFO_DEPTH(DEPTH)
	)
	u_mbox_apb_top
	(
		.rvx_port_21(rvx_port_21),
		.rvx_port_17(rvx_port_17),
		.req(req),
		.status(status),
		.pop(pop),
		.rdata(rdata),
		.slverr(slverr),
		.config_data(config_data),
		.cmd_pulse(cmd_pulse),
		.queues(queues)
	);

	always #(CLK_PERIOD / 2) rvx_port_21 = ~rvx_port_21;

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge rvx_port_21);
		$display("Watchdog expired before the tests completed");
		$display("Test failed");
		$finish;
	end

	// Command pulse follows an access-phase write to CMD by exactly one cycle
	assert property (@(posedge rvx_port_21) disable iff (!rvx_port_17)
		cmd_pulse == $past(req.sel && req.enable && req.write && req.addr == OFS_CMD))
	else
	begin
		$display("[FAIL] cmd_pulse got 0x%h expected 0x%h",
			$sampled(cmd_pulse), !$sampled(cmd_pulse));
		test_errs++;
	end

	// ******************************
	// Helpers
	// ******************************
	task automatic check_val(input string name, input word_t got, input word_t exp);
		begin
			assert (got === exp)
			else
			begin
				$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
				test_errs++;
			end
		end
	endtask

	function automatic paddr_t queue_addr(input int q);
		return paddr_t'(OFS_QUEUE0 + OFS_QUEUE_STEP * q);
	endfunction

	// Setup phase, access phase, then idle
	task automatic bus_write(input paddr_t addr, input word_t data, input logic exp_err);
		begin
			@(negedge rvx_port_21);
			req.sel = 1'b1;
			req.enable = 1'b0;
			req.write = 1'b1;
			req.addr = addr;
			req.wdata = data;
			@(negedge rvx_port_21);
			req.enable = 1'b1;
			#1;
			check_val("slverr", word_t'(slverr), word_t'(exp_err));
			@(negedge rvx_port_21);
			req = '0;
		end
	endtask

	task automatic bus_read(input paddr_t addr, output word_t data, input logic exp_err);
		begin
			@(negedge rvx_port_21);
			req.sel = 1'b1;
			req.enable = 1'b0;
			req.write = 1'b0;
			req.addr = addr;
			req.wdata = '0;
			@(negedge rvx_port_21);
			req.enable = 1'b1;
			#1;
			check_val("slverr", word_t'(slverr), word_t'(exp_err));
			data = rdata;
			@(negedge rvx_port_21);
			req = '0;
		end
	endtask

	// Full queue drops the word
	task automatic push_word(input int q, input word_t data);
		begin
			bus_write(queue_addr(q), data, 1'b0);
			if (model[q].size() < DEPTH)
				model[q].push_back(data);
		end
	endtask

	task automatic pop_queue(input int q);
		begin
			if (model[q].size() > 0)
				check_val($sformatf("queue%0d data", q), queues[q].data, model[q][0]);
			@(negedge rvx_port_21);
			pop[q] = 1'b1;
			@(negedge rvx_port_21);
			pop[q] = 1'b0;
			if (model[q].size() > 0)
				void'(model[q].pop_front());
		end
	endtask

	task automatic read_count_check(input int q);
		word_t got;
		begin
			bus_read(queue_addr(q), got, 1'b0);
			check_val($sformatf("queue%0d count", q), got, word_t'(model[q].size()));
		end
	endtask

	task automatic end_test(input string name);
		begin
			tests_run++;
			if (test_errs == 0)
				$display("test %0d %s: ok", tests_run, name);
			else
			begin
				$display("test %0d %s: %0d errors", tests_run, name, test_errs);
				tests_bad++;
			end
			total_errs += test_errs;
			test_errs = 0;
		end
	endtask

	// ******************************
	// Test sequence
	// ******************************
	initial
	begin
		rvx_port_21 = 1'b0;
		rvx_port_17 = 1'b0;
		req = '0;
		status = '0;
		pop = '0;
		seed = 32'h16f8_4e3f;
		test_errs = 0;
		total_errs = 0;
		tests_run = 0;
		tests_bad = 0;
		cfg_expect = CONFIG_RESET;
		repeat (RESET_CYCLES) @(posedge rvx_port_21);
		@(negedge rvx_port_21);
		rvx_port_17 = 1'b1;

		bus_read(OFS_CONFIG, rd_word, 1'b0);
		check_val("config", rd_word, CONFIG_RESET);
		check_val("config_data", config_data, CONFIG_RESET);
		for (int q = 0; q < NUM_QUEUES; q++)
		begin
			check_val($sformatf("queue%0d empty", q), word_t'(queues[q].empty), 32'd1);
			read_count_check(q);
		end
		check_val("cmd_pulse", word_t'(cmd_pulse), 32'd0);
		end_test("reset values");

		status = 3'b101;
		bus_read(OFS_STATUS, rd_word, 1'b0);
		check_val("status", rd_word, 32'h5);
		cfg_expect = $random(seed);
		bus_write(OFS_CONFIG, cfg_expect, 1'b0);
		check_val("config_data", config_data, cfg_expect);
		bus_read(OFS_CONFIG, rd_word, 1'b0);
		check_val("config", rd_word, cfg_expect);
		bus_write(OFS_STATUS, 32'hFFFF_FFFF, 1'b0);
		bus_read(OFS_STATUS, rd_word, 1'b0);
		check_val("status", rd_word, 32'h5);
		status = 3'b010;
		bus_read(OFS_STATUS, rd_word, 1'b0);
		check_val("status", rd_word, 32'h2);
		end_test("status and config");

		check_val("cmd_pulse", word_t'(cmd_pulse), 32'd0);
		bus_write(OFS_CMD, 32'h1, 1'b0);
		check_val("cmd_pulse", word_t'(cmd_pulse), 32'd1);
		@(negedge rvx_port_21);
		check_val("cmd_pulse", word_t'(cmd_pulse), 32'd0);
		bus_read(OFS_CMD, rd_word, 1'b0);
		check_val("cmd read", rd_word, 32'd0);
		end_test("command pulse");

		for (int q = 0; q < NUM_QUEUES; q++)
		begin
			for (int n = 0; n < 4; n++)
			begin
				wr_word = $random(seed);
				push_word(q, wr_word);
				read_count_check(q);
			end
			// Only the target queue holds words
			for (int o = 0; o < NUM_QUEUES; o++)
				check_val($sformatf("queue%0d count", o), word_t'(queues[o].count),
					word_t'(model[o].size()));
			for (int n = 0; n < 4; n++)
			begin
				pop_queue(q);
				read_count_check(q);
			end
		end
		end_test("queue order");

		for (int n = 0; n < 10; n++)
		begin
			wr_word = $random(seed);
			push_word(2, wr_word);
		end
		read_count_check(2);
		for (int n = 0; n < DEPTH; n++)
			pop_queue(2);
		read_count_check(2);
		pop_queue(2);
		read_count_check(2);
		check_val("queue2 empty", word_t'(queues[2].empty), 32'd1);
		end_test("queue full and empty");

		bus_read(5'h1C, rd_word, 1'b1);
		check_val("rdata", rd_word, 32'd0);
		bus_write(5'h1C, 32'hDEAD_BEEF, 1'b1);
		bus_write(5'h09, 32'h1234_5678, 1'b1);
		bus_write(5'h0E, 32'h0BAD_F00D, 1'b1);
		bus_read(5'h0A, rd_word, 1'b1);
		check_val("rdata", rd_word, 32'd0);
		bus_read(OFS_CONFIG, rd_word, 1'b0);
		check_val("config", rd_word, cfg_expect);
		check_val("config_data", config_data, cfg_expect);
		for (int q = 0; q < NUM_QUEUES; q++)
			read_count_check(q);
		check_val("cmd_pulse", word_t'(cmd_pulse), 32'd0);
		end_test("slave errors");

		$display("tests run: %0d, with errors: %0d, failed checks: %0d",
			tests_run, tests_bad, total_errs);
		if (total_errs == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* mbox_apb_top.f */
logic/mbox_pkg.sv
logic/apb_decode.sv
logic/mbox_fifo.sv
logic/mbox_regs.sv
logic/read_mux.sv
logic/mbox_apb_top.sv
tb/tb_mbox_apb_top.sv

/* Makefile */
# Verilator build and run for the mailbox testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f mbox_apb_top.f \
		--top-module tb_mbox_apb_top -Mdir obj_dir
	./obj_dir/Vtb_mbox_apb_top | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
